// File: include/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// data word and address width
`define DC_WORD_W 32

// number of sets per way
`define DC_SETS 8

// set index width, log2 of DC_SETS
`define DC_IDX_W 3

// tag is what is left of the address above index, block and byte offsets
`define DC_TAG_W 26

// words per block
`define DC_BLK_WORDS 2

// byte offset inside a word
`define DC_BYTOFF_W 2

`endif

// File: rtl/dcache_pkg.sv
`include "dcache_config.svh"

package dcache_pkg;

    typedef logic [`DC_WORD_W-1:0] word_t;
    typedef logic [`DC_TAG_W-1:0] tag_t;
    typedef logic [`DC_IDX_W-1:0] idx_t;
    typedef logic [`DC_BLK_WORDS-1:0][`DC_WORD_W-1:0] dblock_t;

    // address split as tag | index | word in block | byte in word
    typedef struct packed {
        tag_t                               tag;
        idx_t                               idx;
        logic [$clog2(`DC_BLK_WORDS)-1:0]   blkoff;
        logic [`DC_BYTOFF_W-1:0]            bytoff;
    } daddr_t;

    typedef struct packed {
        logic    valid;
        logic    dirty;
        tag_t    tag;
        dblock_t data;
    } dcache_frame_t;

    // request from the datapath, held until hit
    typedef struct packed {
        logic  ren;
        logic  wen;
        logic  halt;
        word_t addr;
        word_t store;
    } dp_req_t;

    typedef struct packed {
        logic  hit;
        word_t load;
        logic  flushed;
    } dp_rsp_t;

    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;
        word_t store;
    } mem_req_t;

    // dwait high holds the current access
    typedef struct packed {
        logic  dwait;
        word_t load;
    } mem_rsp_t;

    typedef struct packed {
        logic          en;
        logic          way;
        idx_t          idx;
        dcache_frame_t frame;
    } frame_wr_t;

    typedef struct packed {
        logic                hit;
        logic                hit_way;
        logic                victim_way;
        dcache_frame_t [1:0] frames;
    } lookup_rsp_t;

    typedef enum logic [3:0] {
        TAG     = 4'd0,
        WB1     = 4'd1,
        WB2     = 4'd2,
        AL1     = 4'd3,
        AL2     = 4'd4,
        HALT    = 4'd5,
        HALTWB1 = 4'd6,
        HALTWB2 = 4'd7,
        FLUSHED = 4'd8
    } ctrl_state_t;

endpackage

// File: rtl/dcache_sets.sv
`timescale 1ns/1ns

`include "dcache_config.svh"

module dcache_sets import dcache_pkg::*; (
    input  logic        CLK,
    input  logic        nRST,
    input  daddr_t      lookup,
    input  logic        touch,
    input  logic        touch_way,
    input  frame_wr_t   wr,
    output lookup_rsp_t rsp
);

    // line state bits, cleared by reset
    logic [`DC_SETS-1:0][1:0] valid;
    logic [`DC_SETS-1:0][1:0] dirty;

    // per set, the way that was not used last
    logic [`DC_SETS-1:0]      lru;

    // tag and data arrays
    tag_t                     tag_mem [`DC_SETS][2];
    dblock_t                  data_mem [`DC_SETS][2];

    logic [1:0]               match;

    // combinational lookup of both ways of one set
    always_comb begin
        rsp = '0;
        match = '0;
        for (int w = 0; w < 2; w++) begin
            rsp.frames[w].valid = valid[lookup.idx][w];
            rsp.frames[w].dirty = dirty[lookup.idx][w];
            rsp.frames[w].tag = tag_mem[lookup.idx][w];
            rsp.frames[w].data = data_mem[lookup.idx][w];
            match[w] = valid[lookup.idx][w] && (tag_mem[lookup.idx][w] == lookup.tag);
        end
        rsp.hit = |match;
        // only one way can hold a given tag
        rsp.hit_way = match[1];
        rsp.victim_way = lru[lookup.idx];
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid <= '0;
            dirty <= '0;
            lru <= '0;
        end else begin
            if (wr.en) begin
                valid[wr.idx][wr.way] <= wr.frame.valid;
                dirty[wr.idx][wr.way] <= wr.frame.dirty;
            end
            // point away from the way just used
            if (touch) begin
                lru[lookup.idx] <= ~touch_way;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (wr.en) begin
            tag_mem[wr.idx][wr.way] <= wr.frame.tag;
            data_mem[wr.idx][wr.way] <= wr.frame.data;
        end
    end

endmodule

// File: rtl/dcache_ctrl.sv
`timescale 1ns/1ns

`include "dcache_config.svh"

module dcache_ctrl import dcache_pkg::*; (
    input  logic        CLK,
    input  logic        nRST,
    input  dp_req_t     dp_req,
    output dp_rsp_t     dp_rsp,
    output mem_req_t    mem_req,
    input  mem_rsp_t    mem_rsp,
    output daddr_t      lookup,
    input  lookup_rsp_t sets_rsp,
    output logic        touch,
    output logic        touch_way,
    output frame_wr_t   wr
);

    ctrl_state_t        state;
    ctrl_state_t        next_state;

    // block base for the current memory transfer
    daddr_t             base_q;
    daddr_t             next_base;
    daddr_t             mem_addr;

    // way being evicted and filled
    logic               way_q;
    logic               next_way;

    // flush walk pointer, set index above, way in bit 0
    logic [`DC_IDX_W:0] flush_ptr;
    logic [`DC_IDX_W:0] next_ptr;
    idx_t               flush_idx;
    logic               flush_way;
    logic               last_slot;

    daddr_t             req_addr;
    logic               flushing;
    logic               word_sel;
    logic               cur_way;
    logic               fill;
    logic               slot_done;
    dcache_frame_t      cur_frame;
    dcache_frame_t      hit_frame;
    dcache_frame_t      victim_frame;
    dcache_frame_t      upd_frame;

    assign req_addr = daddr_t'(dp_req.addr);
    assign flush_idx = flush_ptr[`DC_IDX_W:1];
    assign flush_way = flush_ptr[0];
    assign last_slot = &flush_ptr;

    assign flushing = state inside {HALT, HALTWB1, HALTWB2};
    // second word of the block in these states
    assign word_sel = state inside {WB2, AL2, HALTWB2};

    assign cur_way = flushing ? flush_way : way_q;
    assign cur_frame = sets_rsp.frames[cur_way];
    assign hit_frame = sets_rsp.frames[sets_rsp.hit_way];
    assign victim_frame = sets_rsp.frames[sets_rsp.victim_way];

    // the set to look at: request set, or the walk pointer while flushing
    always_comb begin
        lookup = req_addr;
        if (flushing) begin
            lookup = '0;
            lookup.idx = flush_idx;
        end
    end

    // memory port, all outputs from state and registers only
    always_comb begin
        mem_addr = base_q;
        mem_addr.blkoff = word_sel;
        mem_addr.bytoff = '0;

        mem_req = '0;
        mem_req.addr = mem_addr;
        mem_req.ren = state inside {AL1, AL2};
        mem_req.wen = state inside {WB1, WB2, HALTWB1, HALTWB2};
        if (mem_req.wen) begin
            mem_req.store = cur_frame.data[word_sel];
        end
    end

    always_comb begin
        next_state = state;
        next_base = base_q;
        next_way = way_q;
        next_ptr = flush_ptr;
        dp_rsp = '0;
        dp_rsp.flushed = (state == FLUSHED);
        touch = 1'b0;
        touch_way = sets_rsp.hit_way;
        wr = '0;
        upd_frame = cur_frame;
        fill = 1'b0;
        slot_done = 1'b0;

        case (state)
            TAG: begin
                if (dp_req.halt) begin
                    next_state = HALT;
                    next_ptr = '0;
                end else if (dp_req.ren || dp_req.wen) begin
                    if (sets_rsp.hit) begin
                        dp_rsp.hit = 1'b1;
                        dp_rsp.load = hit_frame.data[req_addr.blkoff];
                        touch = 1'b1;
                        if (dp_req.wen) begin
                            // merge store word into the hit line
                            upd_frame = hit_frame;
                            upd_frame.data[req_addr.blkoff] = dp_req.store;
                            upd_frame.dirty = 1'b1;
                            wr.en = 1'b1;
                            wr.way = sets_rsp.hit_way;
                            wr.idx = req_addr.idx;
                            wr.frame = upd_frame;
                        end
                    end else begin
                        next_way = sets_rsp.victim_way;
                        next_base = req_addr;
                        next_base.blkoff = '0;
                        next_base.bytoff = '0;
                        if (victim_frame.valid && victim_frame.dirty) begin
                            // write back the old block first
                            next_base.tag = victim_frame.tag;
                            next_state = WB1;
                        end else begin
                            next_state = AL1;
                        end
                    end
                end
            end
            WB1: begin
                if (!mem_rsp.dwait) begin
                    next_state = WB2;
                end
            end
            WB2: begin
                if (!mem_rsp.dwait) begin
                    next_base = req_addr;
                    next_base.blkoff = '0;
                    next_base.bytoff = '0;
                    next_state = AL1;
                end
            end
            AL1: begin
                if (!mem_rsp.dwait) begin
                    // line stays invalid until both words are in
                    fill = 1'b1;
                    upd_frame.valid = 1'b0;
                    upd_frame.data[0] = mem_rsp.load;
                    next_state = AL2;
                end
            end
            AL2: begin
                if (!mem_rsp.dwait) begin
                    fill = 1'b1;
                    upd_frame.valid = 1'b1;
                    upd_frame.data[1] = mem_rsp.load;
                    next_state = TAG;
                end
            end
            HALT: begin
                if (cur_frame.valid && cur_frame.dirty) begin
                    next_base = '0;
                    next_base.tag = cur_frame.tag;
                    next_base.idx = flush_idx;
                    next_state = HALTWB1;
                end else begin
                    slot_done = 1'b1;
                end
            end
            HALTWB1: begin
                if (!mem_rsp.dwait) begin
                    next_state = HALTWB2;
                end
            end
            HALTWB2: begin
                if (!mem_rsp.dwait) begin
                    slot_done = 1'b1;
                end
            end
            FLUSHED: begin
                // stays here until reset
                next_state = FLUSHED;
            end
            default: begin
                next_state = TAG;
            end
        endcase

        // fill writes go to the victim way of the request set
        if (fill) begin
            upd_frame.tag = req_addr.tag;
            upd_frame.dirty = 1'b0;
            wr.en = 1'b1;
            wr.way = way_q;
            wr.idx = req_addr.idx;
            wr.frame = upd_frame;
        end

        // invalidate the walked slot and move on
        if (slot_done) begin
            wr.en = 1'b1;
            wr.way = flush_way;
            wr.idx = flush_idx;
            wr.frame = cur_frame;
            wr.frame.valid = 1'b0;
            wr.frame.dirty = 1'b0;
            if (last_slot) begin
                next_state = FLUSHED;
            end else begin
                next_ptr = flush_ptr + 1'b1;
                next_state = HALT;
            end
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= TAG;
            base_q <= '0;
            way_q <= 1'b0;
            flush_ptr <= '0;
        end else begin
            state <= next_state;
            base_q <= next_base;
            way_q <= next_way;
            flush_ptr <= next_ptr;
        end
    end

endmodule

// File: rtl/dcache_top.sv
`timescale 1ns/1ns

module dcache_top import dcache_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,
    input  dp_req_t  dp_req,
    output dp_rsp_t  dp_rsp,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp
);

    daddr_t      lookup;
    lookup_rsp_t sets_rsp;
    logic        touch;
    logic        touch_way;
    frame_wr_t   wr;

    // miss, write-back and flush sequencing
    dcache_ctrl i_ctrl (
        .CLK      (CLK),
        .nRST     (nRST),
        .dp_req   (dp_req),
        .dp_rsp   (dp_rsp),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp),
        .lookup   (lookup),
        .sets_rsp (sets_rsp),
        .touch    (touch),
        .touch_way(touch_way),
        .wr       (wr)
    );

    // two ways of tag, data and state bits
    dcache_sets i_sets (
        .CLK      (CLK),
        .nRST     (nRST),
        .lookup   (lookup),
        .touch    (touch),
        .touch_way(touch_way),
        .wr       (wr),
        .rsp      (sets_rsp)
    );

endmodule

// File: testbench/tb_mem_model.sv
`timescale 1ns/1ns

module tb_mem_model import dcache_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,
    input  mem_req_t mem_req,
    output mem_rsp_t mem_rsp,
    input  word_t    peek_addr,
    output word_t    peek_data,
    output int       wr_count
);

    localparam int WORDS = 4096;

    word_t      mem [WORDS];
    word_t      wr_log [$];
    logic [1:0] wait_cnt;
    logic       busy;
    integer     seed = 32'h40dcc0c9;

    assign busy = mem_req.ren || mem_req.wen;
    assign peek_data = mem[peek_addr[13:2]];

    // read data is valid in the cycle the access is accepted
    always_comb begin
        mem_rsp.dwait = busy && (wait_cnt != 2'd0);
        mem_rsp.load = mem[mem_req.addr[13:2]];
    end

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= 2'd0;
            wr_count <= 0;
            for (int i = 0; i < WORDS; i++) begin
                mem[i] <= word_t'(i * 4) ^ 32'hA5A5A5A5;
            end
        end else if (busy) begin
            if (wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end else begin
                // wait states for the next access, 0 to 3
                wait_cnt <= 2'($random(seed));
                if (mem_req.wen) begin
                    mem[mem_req.addr[13:2]] <= mem_req.store;
                    wr_log.push_back(mem_req.addr);
                    wr_count <= wr_count + 1;
                end
            end
        end
    end

endmodule

// File: testbench/tb_dcache.sv
`timescale 1ns/1ns

`include "dcache_config.svh"

module tb_dcache import dcache_pkg::*; ();

    localparam int MEM_WORDS = 4096;
    localparam int MAX_CYCLES = 20000;

    logic          CLK = 1'b0;
    logic          nRST = 1'b0;
    dp_req_t       dp_req = '0;
    dp_rsp_t       dp_rsp;
    mem_req_t      mem_req;
    mem_rsp_t      mem_rsp;
    word_t         peek_addr = '0;
    word_t         peek_data;
    int            wr_count;

    // expected memory image and cache lines
    word_t         ref_mem [MEM_WORDS];
    dcache_frame_t ref_line [`DC_SETS][2];
    logic          ref_lru [`DC_SETS];

    // addresses the memory should see written, in order
    word_t         wr_addrs [$];

    // memory accesses the cache still has to make in order
    logic          exp_wen [$];
    word_t         exp_addr [$];
    word_t         exp_data [$];

    string         test_name = "reset";
    int            cycles = 0;
    integer        seed = 32'h40dcc0c9;
    mem_req_t      prev_req;
    logic          prev_wait = 1'b0;
    logic          seen_flushed = 1'b0;

    dcache_top i_dut (
        .CLK    (CLK),
        .nRST   (nRST),
        .dp_req (dp_req),
        .dp_rsp (dp_rsp),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp)
    );

    tb_mem_model i_mem (
        .CLK      (CLK),
        .nRST     (nRST),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp),
        .peek_addr(peek_addr),
        .peek_data(peek_data),
        .wr_count (wr_count)
    );

    always #4 CLK = ~CLK;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_word(input string what, input word_t exp, input word_t act);
        assert (exp == act) else begin
            stop_run($sformatf("[FAIL] %s: %s: expected %h, actual %h",
                test_name, what, exp, act));
        end
    endtask

    function automatic void expect_access(input logic w, input word_t a, input word_t d);
        exp_wen.push_back(w);
        exp_addr.push_back(a);
        exp_data.push_back(d);
    endfunction

    // both words of a dirty line go back to its own block address
    function automatic void predict_writeback(input idx_t idx, input logic way);
        word_t a;
        for (int k = 0; k < 2; k++) begin
            a = {ref_line[idx][way].tag, idx, 3'b000} + word_t'(k * 4);
            expect_access(1'b1, a, ref_line[idx][way].data[k]);
            wr_addrs.push_back(a);
        end
    endfunction

    function automatic void predict(input logic w, input word_t a, input word_t d,
                                    output word_t load, output logic hit);
        daddr_t da;
        logic   way;
        word_t  fa;
        da = daddr_t'(a);
        hit = 1'b0;
        way = ref_lru[da.idx];
        for (int k = 0; k < 2; k++) begin
            if (ref_line[da.idx][k].valid && ref_line[da.idx][k].tag == da.tag) begin
                hit = 1'b1;
                way = (k == 1);
            end
        end
        if (!hit) begin
            if (ref_line[da.idx][way].valid && ref_line[da.idx][way].dirty) begin
                predict_writeback(da.idx, way);
            end
            for (int k = 0; k < 2; k++) begin
                fa = {da.tag, da.idx, 3'b000} + word_t'(k * 4);
                expect_access(1'b0, fa, '0);
                ref_line[da.idx][way].data[k] = ref_mem[fa[13:2]];
            end
            ref_line[da.idx][way].valid = 1'b1;
            ref_line[da.idx][way].dirty = 1'b0;
            ref_line[da.idx][way].tag = da.tag;
        end
        // lru names the way not used last
        ref_lru[da.idx] = ~way;
        if (w) begin
            ref_line[da.idx][way].data[da.blkoff] = d;
            ref_line[da.idx][way].dirty = 1'b1;
            ref_mem[a[13:2]] = d;
        end
        load = ref_line[da.idx][way].data[da.blkoff];
    endfunction

    task automatic access(input logic w, input word_t a, input word_t d);
        word_t load;
        logic  hit;
        predict(w, a, d, load, hit);
        @(negedge CLK);
        dp_req.ren = !w;
        dp_req.wen = w;
        dp_req.addr = a;
        dp_req.store = d;
        @(posedge CLK);
        check_word("hit in request cycle", word_t'(hit), word_t'(dp_rsp.hit));
        while (!dp_rsp.hit) begin
            @(posedge CLK);
        end
        if (!w) begin
            check_word("load data", load, dp_rsp.load);
        end
        assert (exp_wen.size() == 0) else begin
            stop_run({test_name, ": hit came before all expected memory accesses"});
        end
        @(negedge CLK);
        dp_req.ren = 1'b0;
        dp_req.wen = 1'b0;
    endtask

    task automatic flush_all();
        for (int s = 0; s < `DC_SETS; s++) begin
            for (int w = 0; w < 2; w++) begin
                if (ref_line[s][w].valid && ref_line[s][w].dirty) begin
                    predict_writeback(idx_t'(s), w == 1);
                end
                ref_line[s][w].valid = 1'b0;
            end
        end
        @(negedge CLK);
        dp_req.halt = 1'b1;
        @(posedge CLK);
        while (!dp_rsp.flushed) begin
            @(posedge CLK);
        end
        assert (exp_wen.size() == 0) else begin
            stop_run("flushed rose before every dirty line was written back");
        end
        repeat (4) @(posedge CLK);
        for (int i = 0; i < MEM_WORDS; i++) begin
            peek_addr = word_t'(i * 4);
            #1;
            check_word("final memory image", ref_mem[i], peek_data);
        end
        check_word("memory write count", word_t'(wr_addrs.size()), word_t'(wr_count));
        for (int i = 0; i < wr_addrs.size(); i++) begin
            check_word("logged write address", wr_addrs[i], i_mem.wr_log[i]);
        end
    endtask

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            stop_run("timeout: the run did not finish within the cycle limit");
        end
    end

    // memory port against the expected access list
    always @(posedge CLK) begin
        if (nRST) begin
            if (prev_wait) begin
                assert (mem_req == prev_req) else begin
                    stop_run($sformatf("[FAIL] %s: stalled request: expected %h, actual %h",
                        test_name, prev_req, mem_req));
                end
            end
            if ((mem_req.ren || mem_req.wen) && !mem_rsp.dwait) begin
                assert (exp_wen.size() > 0) else begin
                    stop_run({test_name, ": memory access made when none was expected"});
                end
                check_word("access is a write", word_t'(exp_wen[0]), word_t'(mem_req.wen));
                check_word("memory address", exp_addr[0], mem_req.addr);
                if (mem_req.wen) begin
                    check_word("write-back data", exp_data[0], mem_req.store);
                end
                void'(exp_wen.pop_front());
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
            if (seen_flushed) begin
                assert (dp_rsp.flushed) else stop_run("flushed fell after it had risen");
            end
            prev_wait <= mem_rsp.dwait;
            prev_req <= mem_req;
            seen_flushed <= seen_flushed || dp_rsp.flushed;
        end
    end

    initial begin
        daddr_t      ra;
        logic [31:0] r;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = word_t'(i * 4) ^ 32'hA5A5A5A5;
        end
        for (int s = 0; s < `DC_SETS; s++) begin
            ref_lru[s] = 1'b0;
            ref_line[s][0] = '0;
            ref_line[s][1] = '0;
        end
        repeat (8) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        test_name = "read miss then hit";
        access(1'b0, 32'h0000_0100, '0);
        access(1'b0, 32'h0000_0104, '0);

        test_name = "write hit and read back";
        access(1'b1, 32'h0000_0104, 32'hCAFE_0001);
        access(1'b0, 32'h0000_0104, '0);
        access(1'b1, 32'h0000_0100, 32'hCAFE_0002);
        access(1'b0, 32'h0000_0100, '0);

        // three tags in set 2 with the first two dirty
        test_name = "dirty eviction";
        access(1'b1, 32'h0000_0410, 32'h1111_0000);
        access(1'b1, 32'h0000_0454, 32'h2222_0000);
        access(1'b0, 32'h0000_0490, '0);
        access(1'b0, 32'h0000_0414, '0);

        // A in set 5 is touched again so C pushes out B
        test_name = "lru order";
        access(1'b0, 32'h0000_0828, '0);
        access(1'b0, 32'h0000_0868, '0);
        access(1'b0, 32'h0000_082C, '0);
        access(1'b0, 32'h0000_08A8, '0);
        access(1'b0, 32'h0000_0828, '0);
        access(1'b0, 32'h0000_086C, '0);

        test_name = "random traffic";
        for (int n = 0; n < 40; n++) begin
            r = $random(seed);
            ra = '0;
            ra.tag = tag_t'(8'h30 + r[1:0]);
            ra.idx = r[4:2];
            ra.blkoff = r[5];
            access(r[6], word_t'(ra), $random(seed));
        end

        test_name = "halt flush";
        flush_all();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: dcache.f
+incdir+include
rtl/dcache_pkg.sv
rtl/dcache_sets.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
testbench/tb_mem_model.sv
testbench/tb_dcache.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the data cache testbench with Verilator, run it and look for the pass line
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f dcache.f \
    --top-module tb_dcache \
    -o sim_dcache

output=$(./obj_dir/sim_dcache 2>&1) || true
echo "$output"

if grep -qF "*** TEST PASSED ***" <<< "$output"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
